/* hw/zx_pkg.sv */
`default_nettype none

package zx_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [15:0] ide_word_t;

	localparam int NUM_LATCH = 4; // writable byte ports
	typedef logic [NUM_LATCH-1:0] latch_vec_t;

	// latch slots
	localparam int LATCH_FE    = 0;
	localparam int LATCH_7FFD  = 1;
	localparam int LATCH_EFF7  = 2;
	localparam int LATCH_SDCFG = 3;

	// sdcfg comes up with card deselected
	localparam byte_t LATCH_RESET [NUM_LATCH] = '{8'h00, 8'h00, 8'h00, 8'h02};

	// low address bytes of the ports
	localparam byte_t PORT_FE = 8'hFE;
	localparam byte_t PORT_FD = 8'hFD; // 7ffd, fffd, bffd
	localparam byte_t PORT_F7 = 8'hF7; // eff7

	localparam byte_t NIDE_10 = 8'h10; // data low
	localparam byte_t NIDE_11 = 8'h11; // data high
	localparam byte_t NIDE_30 = 8'h30;
	localparam byte_t NIDE_50 = 8'h50;
	localparam byte_t NIDE_70 = 8'h70;
	localparam byte_t NIDE_90 = 8'h90;
	localparam byte_t NIDE_B0 = 8'hB0;
	localparam byte_t NIDE_D0 = 8'hD0;
	localparam byte_t NIDE_F0 = 8'hF0;
	localparam byte_t NIDE_C8 = 8'hC8; // cs1 block

	localparam byte_t VG_COM = 8'h1F;
	localparam byte_t VG_TRK = 8'h3F;
	localparam byte_t VG_SEC = 8'h5F;
	localparam byte_t VG_DAT = 8'h7F;
	localparam byte_t VG_SYS = 8'hFF;

	localparam byte_t KJOY   = 8'h1F; // shares 1f with vg_com, outside dos
	localparam byte_t KMOUSE = 8'hDF;

	localparam byte_t SD_CFG = 8'h77;
	localparam byte_t SD_DAT = 8'h57;

	typedef enum logic {DOS_OFF = 1'b0, DOS_ON = 1'b1} dos_state_t;

endpackage

`default_nettype wire

/* hw/port_latch.sv */
`timescale 1ns/10ps
`default_nettype none

module port_latch
#(
	parameter zx_pkg::byte_t RESET_VALUE = 8'h00
)
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          wr,
	input  zx_pkg::byte_t din,
	output zx_pkg::byte_t q
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			q <= RESET_VALUE;
		else if (wr)
			q <= din; // one strobe, one load
	end

endmodule

`default_nettype wire

/* hw/io_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module io_decode
(
	input  logic               clk,
	input  logic               rst_n,
	input  zx_pkg::addr_t      a,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               dos,
	input  logic               lock_7ffd,
	input  logic [4:0]         keyout,
	input  zx_pkg::byte_t      idein_lo,
	input  zx_pkg::byte_t      ide_hi_byte,
	input  logic               vg_intrq,
	input  logic               vg_drq,
	input  zx_pkg::byte_t      sd_dataout,
	output zx_pkg::latch_vec_t latch_wr,
	output logic               wr_7ffd,
	output logic               ide_hi_wr,
	output logic               ide_lo_rd,
	output logic               sd_access,
	output logic               vg_wrff,
	output logic               porthit,
	output logic               dataout,
	output zx_pkg::byte_t      dout,
	output logic               ay_bc1,
	output logic               ay_bdir,
	output logic               vg_cs_n
);

	zx_pkg::byte_t loa;
	logic io_wr_q; // previous cycle saw an io write
	logic io_rd_q;
	logic port_wr;
	logic port_rd;
	logic vg_port;
	logic ide_port;
	logic external_port;

	assign loa = a[7:0];

	// edge detect on the io cycle, one strobe however long the z80 holds it
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_q <= 1'b0;
			io_rd_q <= 1'b0;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			io_wr_q <= !(iorq_n || wr_n);
			io_rd_q <= !(iorq_n || rd_n);
			port_wr <= !io_wr_q && !iorq_n && !wr_n;
			port_rd <= !io_rd_q && !iorq_n && !rd_n;
		end
	end

	assign vg_port = (loa == zx_pkg::VG_COM) || (loa == zx_pkg::VG_TRK) ||
	                 (loa == zx_pkg::VG_SEC) || (loa == zx_pkg::VG_DAT);

	assign ide_port = (loa == zx_pkg::NIDE_10) || (loa == zx_pkg::NIDE_30) ||
	                  (loa == zx_pkg::NIDE_50) || (loa == zx_pkg::NIDE_70) ||
	                  (loa == zx_pkg::NIDE_90) || (loa == zx_pkg::NIDE_B0) ||
	                  (loa == zx_pkg::NIDE_D0) || (loa == zx_pkg::NIDE_F0) ||
	                  (loa == zx_pkg::NIDE_C8);

	// strobe steering
	assign wr_7ffd = port_wr && (loa == zx_pkg::PORT_FD) && !a[15] && !lock_7ffd;

	assign latch_wr[zx_pkg::LATCH_FE]    = port_wr && (loa == zx_pkg::PORT_FE);
	assign latch_wr[zx_pkg::LATCH_7FFD]  = wr_7ffd;
	assign latch_wr[zx_pkg::LATCH_EFF7]  = port_wr && (loa == zx_pkg::PORT_F7) &&
	                                       (a[15:8] == 8'hEF);
	assign latch_wr[zx_pkg::LATCH_SDCFG] = port_wr && (loa == zx_pkg::SD_CFG);

	assign ide_hi_wr = port_wr && (loa == zx_pkg::NIDE_11);
	assign ide_lo_rd = port_rd && (loa == zx_pkg::NIDE_10); // grabs the high half too
	assign sd_access = (port_wr || port_rd) && (loa == zx_pkg::SD_DAT);
	assign vg_wrff   = port_wr && dos && (loa == zx_pkg::VG_SYS);

	// ports this block answers, vg set only in dos
	always_comb
	begin
		porthit = (loa == zx_pkg::PORT_FE) || (loa == zx_pkg::PORT_FD) ||
		          (loa == zx_pkg::PORT_F7) || (loa == zx_pkg::NIDE_11) || ide_port ||
		          (loa == zx_pkg::KMOUSE) || (loa == zx_pkg::SD_CFG) ||
		          (loa == zx_pkg::SD_DAT);
		if (dos && (vg_port || (loa == zx_pkg::VG_SYS)))
			porthit = 1'b1;
		if (!dos && (loa == zx_pkg::KJOY))
			porthit = 1'b1;
	end

	// data for these comes from the ay or the vg93, not from dout
	assign external_port = ((loa == zx_pkg::PORT_FD) && (a[15:14] == 2'b11)) ||
	                       (vg_port && dos);

	assign dataout = porthit && !iorq_n && !rd_n && !external_port;

	always_comb
	begin
		case (loa)
			zx_pkg::PORT_FE: dout = {1'b1, 1'b0, 1'b0, keyout}; // tape in reads 0
			zx_pkg::NIDE_10, zx_pkg::NIDE_30, zx_pkg::NIDE_50, zx_pkg::NIDE_70,
			zx_pkg::NIDE_90, zx_pkg::NIDE_B0, zx_pkg::NIDE_D0, zx_pkg::NIDE_F0,
			zx_pkg::NIDE_C8: dout = idein_lo;
			zx_pkg::NIDE_11: dout = ide_hi_byte;
			zx_pkg::VG_SYS:  dout = {vg_intrq, vg_drq, 6'b111111};
			zx_pkg::KJOY:    dout = 8'h00;
			zx_pkg::KMOUSE:  dout = 8'hFF;
			zx_pkg::SD_CFG:  dout = 8'h00; // card present, writable
			zx_pkg::SD_DAT:  dout = sd_dataout;
			default:         dout = 8'hFF;
		endcase
	end

	// ay: fffd latches address, bffd writes data
	assign ay_bc1  = (loa == zx_pkg::PORT_FD) && (a[15:14] == 2'b11) && !iorq_n &&
	                 (!rd_n || !wr_n);
	assign ay_bdir = (loa == zx_pkg::PORT_FD) && a[15] && !iorq_n && !wr_n;

	assign vg_cs_n = !(dos && vg_port && !iorq_n && (!rd_n || !wr_n));

endmodule

`default_nettype wire

/* hw/paging_ctl.sv */
`timescale 1ns/10ps
`default_nettype none

module paging_ctl
(
	input  logic          clk,
	input  logic          rst_n,
	input  zx_pkg::byte_t latch_q [zx_pkg::NUM_LATCH],
	input  logic          wr_7ffd,
	input  logic          din4,
	input  logic [1:0]    rstrom,
	input  zx_pkg::addr_t a,
	input  logic          mreq_n,
	input  logic          m1_n,
	output zx_pkg::byte_t p7ffd,
	output zx_pkg::byte_t peff7,
	output logic          lock_7ffd,
	output logic [2:0]    border,
	output logic          beep,
	output logic          sdcs_n,
	output logic          dos
);

	zx_pkg::byte_t      q_fe;
	zx_pkg::byte_t      q_7ffd;
	zx_pkg::byte_t      q_eff7;
	zx_pkg::byte_t      q_sdcfg;
	logic               lock_1m;
	logic               rom_bit;
	logic               rst_sync1;
	logic               rst_sync2;
	zx_pkg::dos_state_t dos_state;

	assign q_fe    = latch_q[zx_pkg::LATCH_FE];
	assign q_7ffd  = latch_q[zx_pkg::LATCH_7FFD];
	assign q_eff7  = latch_q[zx_pkg::LATCH_EFF7];
	assign q_sdcfg = latch_q[zx_pkg::LATCH_SDCFG];

	assign border = q_fe[2:0];
	assign beep   = q_fe[4];
	assign sdcs_n = q_sdcfg[1];

	// eff7 bit 2 locks out the upper memory
	assign lock_1m   = q_eff7[2];
	assign lock_7ffd = q_7ffd[5] & lock_1m; // 48k lock only sticks with 1m lock on

	assign p7ffd = {(lock_1m ? 3'b000 : q_7ffd[7:5]), rom_bit, q_7ffd[3:0]};

	// turbo and video bits stay live under the lock
	assign peff7 = lock_1m ? {2'b00, q_eff7[5], q_eff7[4], 3'b000, q_eff7[0]} : q_eff7;

	// two stage reset sync, held while rst_n low
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_sync1 <= 1'b1;
			rst_sync2 <= 1'b1;
		end
		else
		begin
			rst_sync1 <= 1'b0;
			rst_sync2 <= rst_sync1;
		end
	end

	// rom select, reloaded from rstrom during reset
	always_ff @(posedge clk)
	begin
		if (rst_sync2)
			rom_bit <= rstrom[0];
		else if (wr_7ffd)
			rom_bit <= din4;
	end

	// trdos entry on fetch from 3dxx in basic48 rom, exit on fetch from ram
	always_ff @(posedge clk)
	begin
		if (rst_sync2)
			dos_state <= rstrom[1] ? zx_pkg::DOS_OFF : zx_pkg::DOS_ON;
		else if (!mreq_n && !m1_n)
		begin
			if ((a[15:8] == 8'h3D) && rom_bit)
				dos_state <= zx_pkg::DOS_ON;
			else if (a[15:14] != 2'b00)
				dos_state <= zx_pkg::DOS_OFF;
		end
	end

	assign dos = (dos_state == zx_pkg::DOS_ON);

endmodule

`default_nettype wire

/* hw/ide_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module ide_bridge
(
	input  logic              clk,
	input  zx_pkg::addr_t     a,
	input  zx_pkg::byte_t     din,
	input  zx_pkg::ide_word_t idein,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              ide_hi_wr,
	input  logic              ide_lo_rd,
	output zx_pkg::ide_word_t ideout,
	output zx_pkg::byte_t     ide_hi_byte,
	output logic [2:0]        ide_a,
	output logic              ide_cs0_n,
	output logic              ide_cs1_n,
	output logic              ide_rd_n,
	output logic              ide_wr_n,
	output logic              idedataout
);

	zx_pkg::byte_t hi_out; // written via port 11 before the 10 write
	logic          ide_port;

	always_ff @(posedge clk)
	begin
		if (ide_hi_wr)
			hi_out <= din;
		if (ide_lo_rd)
			ide_hi_byte <= idein[15:8]; // held for the following read of 11
	end

	assign ideout = {hi_out, din};

	always_comb
	begin
		case (a[7:0])
			zx_pkg::NIDE_10, zx_pkg::NIDE_30, zx_pkg::NIDE_50, zx_pkg::NIDE_70,
			zx_pkg::NIDE_90, zx_pkg::NIDE_B0, zx_pkg::NIDE_D0, zx_pkg::NIDE_F0,
			zx_pkg::NIDE_C8: ide_port = 1'b1;
			default:         ide_port = 1'b0;
		endcase
	end

	// register select straight from a7..a5
	assign ide_a = a[7:5];

	// chip selects follow the address only, older drives want them early
	assign ide_cs0_n = !(ide_port && (a[7:0] != zx_pkg::NIDE_C8));
	assign ide_cs1_n = !(ide_port && (a[7:0] == zx_pkg::NIDE_C8));

	assign ide_rd_n   = iorq_n || rd_n || !ide_port;
	assign ide_wr_n   = iorq_n || wr_n || !ide_port;
	assign idedataout = ide_rd_n; // bus driven toward the drive unless reading

endmodule

`default_nettype wire

/* hw/sd_start_cdc.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_start_cdc
(
	input  logic clk,
	input  logic fclk,
	input  logic rst_n,
	input  logic sd_access,
	output logic sd_start
);

	logic       toggle; // flips once per access, clk domain
	logic [2:0] sync;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			toggle <= 1'b0;
		else if (sd_access)
			toggle <= !toggle;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			sync <= 3'b000;
		else
			sync <= {sync[1:0], toggle};
	end

	// each toggle edge gives one fclk pulse
	assign sd_start = sync[1] ^ sync[2];

endmodule

`default_nettype wire

/* hw/zx_ports.sv */
`timescale 1ns/10ps
`default_nettype none

module zx_ports
(
	input  logic              clk,        // z80 clock
	input  logic              fclk,       // fpga clock, spi side
	input  logic              rst_n,
	input  zx_pkg::byte_t     din,
	output zx_pkg::byte_t     dout,
	output logic              dataout,
	input  zx_pkg::addr_t     a,
	input  logic              iorq_n,
	input  logic              mreq_n,
	input  logic              m1_n,
	input  logic              rd_n,
	input  logic              wr_n,
	output logic              porthit,
	output zx_pkg::ide_word_t ideout,
	input  zx_pkg::ide_word_t idein,
	output logic              idedataout,
	output logic [2:0]        ide_a,
	output logic              ide_cs0_n,
	output logic              ide_cs1_n,
	output logic              ide_rd_n,
	output logic              ide_wr_n,
	input  logic [4:0]        keyout,
	input  logic [1:0]        rstrom,
	output logic [2:0]        border,
	output logic              beep,
	output logic              dos,
	output logic              ay_bdir,
	output logic              ay_bc1,
	output zx_pkg::byte_t     p7ffd,
	output zx_pkg::byte_t     peff7,
	output logic              vg_cs_n,
	input  logic              vg_intrq,
	input  logic              vg_drq,
	output logic              vg_wrff,
	output logic              sdcs_n,
	output logic              sd_start,
	output zx_pkg::byte_t     sd_datain,
	input  zx_pkg::byte_t     sd_dataout
);

	zx_pkg::latch_vec_t latch_wr;
	zx_pkg::byte_t      latch_q [zx_pkg::NUM_LATCH];
	zx_pkg::byte_t      ide_hi_byte;
	logic               wr_7ffd;
	logic               lock_7ffd;
	logic               ide_hi_wr;
	logic               ide_lo_rd;
	logic               sd_access;

	io_decode u_decode (
		.clk(clk), .rst_n(rst_n), .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.dos(dos), .lock_7ffd(lock_7ffd), .keyout(keyout), .idein_lo(idein[7:0]),
		.ide_hi_byte(ide_hi_byte), .vg_intrq(vg_intrq), .vg_drq(vg_drq),
		.sd_dataout(sd_dataout), .latch_wr(latch_wr), .wr_7ffd(wr_7ffd),
		.ide_hi_wr(ide_hi_wr), .ide_lo_rd(ide_lo_rd), .sd_access(sd_access),
		.vg_wrff(vg_wrff), .porthit(porthit), .dataout(dataout), .dout(dout),
		.ay_bc1(ay_bc1), .ay_bdir(ay_bdir), .vg_cs_n(vg_cs_n)
	);

	// fe, 7ffd, eff7, sdcfg
	for (genvar i = 0; i < zx_pkg::NUM_LATCH; i++)
	begin : g_latch
		port_latch #(.RESET_VALUE(zx_pkg::LATCH_RESET[i])) u_latch (
			.clk(clk), .rst_n(rst_n), .wr(latch_wr[i]), .din(din), .q(latch_q[i])
		);
	end

	paging_ctl u_paging (
		.clk(clk), .rst_n(rst_n), .latch_q(latch_q), .wr_7ffd(wr_7ffd), .din4(din[4]),
		.rstrom(rstrom), .a(a), .mreq_n(mreq_n), .m1_n(m1_n), .p7ffd(p7ffd),
		.peff7(peff7), .lock_7ffd(lock_7ffd), .border(border), .beep(beep),
		.sdcs_n(sdcs_n), .dos(dos)
	);

	ide_bridge u_ide (
		.clk(clk), .a(a), .din(din), .idein(idein), .iorq_n(iorq_n), .rd_n(rd_n),
		.wr_n(wr_n), .ide_hi_wr(ide_hi_wr), .ide_lo_rd(ide_lo_rd), .ideout(ideout),
		.ide_hi_byte(ide_hi_byte), .ide_a(ide_a), .ide_cs0_n(ide_cs0_n),
		.ide_cs1_n(ide_cs1_n), .ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n),
		.idedataout(idedataout)
	);

	sd_start_cdc u_sd_cdc (
		.clk(clk), .fclk(fclk), .rst_n(rst_n), .sd_access(sd_access), .sd_start(sd_start)
	);

	// reads clock out all ones
	assign sd_datain = wr_n ? 8'hFF : din;

endmodule

`default_nettype wire

/* test/tb_zx_ports.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_zx_ports;

	logic              clk;
	logic              fclk;
	logic              rst_n;
	zx_pkg::byte_t     din;
	zx_pkg::byte_t     dout;
	logic              dataout;
	zx_pkg::addr_t     a;
	logic              iorq_n;
	logic              mreq_n;
	logic              m1_n;
	logic              rd_n;
	logic              wr_n;
	logic              porthit;
	zx_pkg::ide_word_t ideout;
	zx_pkg::ide_word_t idein;
	logic              idedataout;
	logic [2:0]        ide_a;
	logic              ide_cs0_n;
	logic              ide_cs1_n;
	logic              ide_rd_n;
	logic              ide_wr_n;
	logic [4:0]        keyout;
	logic [1:0]        rstrom;
	logic [2:0]        border;
	logic              beep;
	logic              dos;
	logic              ay_bdir;
	logic              ay_bc1;
	zx_pkg::byte_t     p7ffd;
	zx_pkg::byte_t     peff7;
	logic              vg_cs_n;
	logic              vg_intrq;
	logic              vg_drq;
	logic              vg_wrff;
	logic              sdcs_n;
	logic              sd_start;
	zx_pkg::byte_t     sd_datain;
	zx_pkg::byte_t     sd_dataout;

	// one entry per pattern line
	logic [7:0]    pat_op [$];
	zx_pkg::addr_t pat_addr [$];
	zx_pkg::byte_t pat_data [$];
	logic [63:0]   pat_check [$];
	logic [15:0]   pat_exp [$];

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int limit = 0; // 0 until the patterns are loaded
	int start_count = 0;
	int wrff_count = 0;
	int idx;

	zx_ports dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = !clk;
	end

	initial
	begin
		fclk = 1'b0;
		#1.25; // fclk edges never meet clk edges
		forever #2.5 fclk = !fclk;
	end

	always @(posedge fclk)
		if (sd_start)
			start_count <= start_count + 1;

	always @(posedge clk)
		if (vg_wrff)
			wrff_count <= wrff_count + 1;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("checks %0d, errors %0d", checks, errors + 1);
			$display("Errors found");
			$finish;
		end
	end

	task automatic load_patterns();
		int            fd;
		int            code;
		logic [63:0]   tok;
		logic [1023:0] rest;
		zx_pkg::addr_t f_addr;
		zx_pkg::byte_t f_data;
		logic [63:0]   f_check;
		logic [15:0]   f_exp;
		logic          good;
		fd = $fopen("test/port_patterns.txt", "r");
		assert (fd != 0)
		else
		begin
			errors++;
			$display("pattern file test/port_patterns.txt could not be opened");
		end
		if (fd != 0)
		begin
			code = $fscanf(fd, "%s", tok);
			while (code == 1)
			begin
				if (tok == 64'("#"))
					code = $fgets(rest, fd); // column notes
				else
				begin
					code = $fscanf(fd, "%h %h %s %h", f_addr, f_data, f_check, f_exp);
					good = (code == 4) &&
					       (tok == 64'("W") || tok == 64'("R") || tok == 64'("F"));
					assert (good)
					else
					begin
						errors++;
						$display("pattern line after entry %0d cannot be parsed", pat_op.size());
					end
					if (good)
					begin
						pat_op.push_back(tok[7:0]);
						pat_addr.push_back(f_addr);
						pat_data.push_back(f_data);
						pat_check.push_back(f_check);
						pat_exp.push_back(f_exp);
					end
				end
				code = $fscanf(fd, "%s", tok);
			end
			$fclose(fd);
		end
	endtask

	task automatic sample_output(input logic [63:0] check, output logic [15:0] value,
	                             output logic known);
		known = 1'b1;
		value = 16'h0000;
		case (check)
			64'("border"): value = {13'd0, border};
			64'("beep"):   value = {15'd0, beep};
			64'("dout"):   value = {8'd0, dout};
			64'("hit"):    value = {14'd0, porthit, dataout};
			64'("p7ffd"):  value = {8'd0, p7ffd};
			64'("peff7"):  value = {8'd0, peff7};
			64'("dos"):    value = {15'd0, dos};
			64'("vgcs"):   value = {15'd0, vg_cs_n};
			64'("ay"):     value = {14'd0, ay_bdir, ay_bc1};
			64'("ideout"): value = ideout;
			64'("cs1"):    value = {15'd0, ide_cs1_n};
			64'("sdcs"):   value = {15'd0, sdcs_n};
			64'("start"), 64'("none"): value = 16'h0000;
			default:       known = 1'b0;
		endcase
	endtask

	// nemoide register number of a port, -1 outside the drive set
	function automatic int ide_reg(input zx_pkg::byte_t port);
		case (port)
			8'h10:   return 0;
			8'h30:   return 1;
			8'h50:   return 2;
			8'h70:   return 3;
			8'h90:   return 4;
			8'hB0:   return 5;
			8'hD0:   return 6;
			8'hF0:   return 7;
			8'hC8:   return 6; // device control in the cs1 block
			default: return -1;
		endcase
	endfunction

	// ide lines and sd_datain while the z80 cycle is active
	task automatic check_bus(input int i, input logic [7:0] op, input zx_pkg::byte_t port,
	                         input zx_pkg::byte_t d);
		int          reg_no;
		logic        is_ide;
		logic [15:0] expected;
		logic [15:0] actual;
		reg_no = ide_reg(port);
		is_ide = (reg_no >= 0);
		expected = {is_ide ? 3'(reg_no) : 3'b000, !(is_ide && port != 8'hC8),
		            port != 8'hC8, !(is_ide && op == "R"), !(is_ide && op == "W"),
		            !(is_ide && op == "R"), (op == "W") ? d : 8'hFF};
		actual = {is_ide ? ide_a : 3'b000, ide_cs0_n, ide_cs1_n, ide_rd_n, ide_wr_n,
		          idedataout, sd_datain};
		checks++;
		assert (actual == expected)
		else
		begin
			errors++;
			$display("Fail bus #%0d: expected %h, actual %h", i, expected, actual);
		end
	endtask

	// one z80 cycle held for 3 clocks, then idle until sd_start has settled
	task automatic run_op(input int i);
		logic [7:0]    op;
		zx_pkg::addr_t addr;
		zx_pkg::byte_t d;
		logic [63:0]   check;
		logic [15:0]   actual;
		logic          known;
		int            base;
		int            wrff_base;
		op = pat_op[i];
		addr = pat_addr[i];
		d = pat_data[i];
		check = pat_check[i];
		@(posedge clk);
		base = start_count;
		wrff_base = wrff_count;
		a <= addr;
		case (op)
			"W":
			begin
				din <= d;
				iorq_n <= 1'b0;
				wr_n <= 1'b0;
			end
			"R":
			begin
				keyout <= d[4:0];
				idein <= {~d, d}; // high half is the inverse of the low
				sd_dataout <= d;
				vg_intrq <= d[7];
				vg_drq <= d[6];
				iorq_n <= 1'b0;
				rd_n <= 1'b0;
			end
			default:
			begin
				mreq_n <= 1'b0;
				m1_n <= 1'b0;
			end
		endcase
		repeat (2) @(posedge clk);
		@(negedge clk);
		sample_output(check, actual, known); // latch loaded, cycle still active
		check_bus(i, op, addr[7:0], d);
		@(posedge clk);
		iorq_n <= 1'b1;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		mreq_n <= 1'b1;
		m1_n <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (check == 64'("start"))
			actual = 16'(start_count - base);
		if (!(op == "W" && addr[7:0] == 8'hFF))
		begin
			checks++;
			assert (wrff_count == wrff_base)
			else
			begin
				errors++;
				$display("Fail vg_wrff #%0d: expected 0, actual %0d", i, wrff_count - wrff_base);
			end
		end
		assert (known)
		else
		begin
			errors++;
			$display("pattern %0d names a check that does not exist: %0s", i, check);
		end
		if (known && check != 64'("none"))
		begin
			checks++;
			assert (actual == pat_exp[i])
			else
			begin
				errors++;
				$display("Fail %0s #%0d: expected %h, actual %h", check, i, pat_exp[i], actual);
			end
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		din = 8'h00;
		a = 16'h0000;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		m1_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		idein = 16'h0000;
		keyout = 5'h1F;
		rstrom = 2'b01; // basic48 rom, trdos active
		vg_intrq = 1'b0;
		vg_drq = 1'b0;
		sd_dataout = 8'hFF;
		load_patterns();
		limit = pat_op.size() * 6 + 100;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		for (idx = 0; idx < pat_op.size(); idx++)
			run_op(idx);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* test/port_patterns.txt */
# op W io write, R io read, F opcode fetch; then address, data, check, expected (hex)
# on reads the data byte drives keyout, idein {~d,d}, sd_dataout and vg_intrq/vg_drq
R 00FE 00 sdcs 0001
R 00FE 00 dos 0001
R 00FE 00 p7ffd 0010
W 00FE 15 border 0005
W 00FE 15 beep 0001
W 00FE 03 beep 0000
R 00FE 0A dout 008A
F 8000 00 dos 0000
R 001F 00 vgcs 0001
R 001F 00 hit 0003
F 3D00 00 dos 0001
R 001F 00 vgcs 0000
R 001F 00 hit 0002
R 00FF 80 dout 00BF
F 8000 00 dos 0000
W 7FFD 17 p7ffd 0017
W 7FFD C3 p7ffd 00C3
W EFF7 FF peff7 0031
R 00FE 00 p7ffd 0003
W 7FFD 20 p7ffd 0000
W 7FFD 1F p7ffd 0000
W EFF7 00 p7ffd 0020
W 7FFD 10 p7ffd 0010
W FFFD 07 ay 0003
W BFFD 00 ay 0002
R FFFD 00 ay 0001
W 0011 AB none 0000
W 0010 CD ideout ABCD
R 0010 5A dout 005A
R 0011 00 dout 00A5
R 00C8 00 cs1 0000
R 0010 00 cs1 0001
W 0077 00 sdcs 0000
W 0057 3C start 0001
R 0057 C3 dout 00C3
R 0057 00 start 0001
W 0077 02 sdcs 0001

/* Makefile */
# build and run the zx_ports testbench with verilator

.PHONY: help test clean

help:
	@echo "make test   build with verilator and run tb_zx_ports"
	@echo "make clean  remove the verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_zx_ports -Mdir obj_dir -f all.f
	./obj_dir/Vtb_zx_ports | tee /dev/stderr | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* all.f */
hw/zx_pkg.sv
hw/port_latch.sv
hw/io_decode.sv
hw/paging_ctl.sv
hw/ide_bridge.sv
hw/sd_start_cdc.sv
hw/zx_ports.sv
test/tb_zx_ports.sv
